/* source/i2c_bridge_pkg.sv */
package i2c_bridge_pkg;

	// host register offsets
	localparam logic [5:0] REG_CTRL = 6'h00;
	localparam logic [5:0] REG_ADDR = 6'h04;
	localparam logic [5:0] REG_TX   = 6'h08;
	localparam logic [5:0] REG_RX   = 6'h0c;
	localparam logic [5:0] REG_RBT  = 6'h14;

	localparam logic [31:0] UNMAPPED_DATA = 32'hdead_dead;

	// queue geometry, counts are FIFO_CW bits wide
	localparam int                 FIFO_CW    = 9;
	localparam logic [FIFO_CW-1:0] FIFO_DEPTH = 9'd256;
	localparam logic [FIFO_CW-1:0] PKG_LEN    = 9'd10;  // words per packet

	// fixed bridge slave addresses
	localparam logic [6:0] BRG_CMD_ADDR  = 7'h40;
	localparam logic [6:0] BRG_DATA_ADDR = 7'h41;

	// bridge command bytes
	localparam logic [7:0] BRG_CS_ON   = 8'h00;
	localparam logic [7:0] BRG_CS_OFF  = 8'h01;
	localparam logic [7:0] BRG_EN_ON   = 8'h02;
	localparam logic [7:0] BRG_EN_OFF  = 8'h03;
	localparam logic [7:0] BRG_DL_DONE = 8'h04;

	// control word, command bits on write and status on read
	typedef union packed {
		struct packed {
			logic [5:0]  rsvd_hi;
			logic        unmask;
			logic        mask;
			logic        soft_rst;
			logic        tx_flush;
			logic        rx_flush;
			logic        clr_rd_err;
			logic        clr_rd_done;
			logic        clr_wr_done;
			logic [17:0] rsvd_lo;
		} wr;
		struct packed {
			logic [6:0] rsvd_hi;
			logic       mask;
			logic [2:0] rsvd_mid;
			logic       rd_err;
			logic       rd_done;
			logic       wr_done;
			logic [8:0] tx_count;
			logic [8:0] rx_count;
		} rd;
	} ctrl_word_u;

endpackage

/* source/word_fifo.sv */
module word_fifo (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        flush,
	input  logic        wr_en,
	input  logic [31:0] din,
	input  logic        rd_en,
	output logic [31:0] dout,
	output logic [i2c_bridge_pkg::FIFO_CW-1:0] count
);

	logic [31:0] mem [i2c_bridge_pkg::FIFO_DEPTH];
	logic [$clog2(i2c_bridge_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(i2c_bridge_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en & (count != i2c_bridge_pkg::FIFO_DEPTH);
	assign do_rd = rd_en & (count != '0);
	assign dout  = mem[rd_ptr];  // head shows before the pop

	always_ff @(posedge CLK_I) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;  // both or neither
			endcase
		end
	end

	// callers must respect count on both sides
	a_no_over_under: assert property (@(posedge CLK_I) disable iff (RST_I)
		!(rd_en && count == '0) && !(wr_en && count == i2c_bridge_pkg::FIFO_DEPTH));

endmodule

/* source/wb_reg_bank.sv */
module wb_reg_bank (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        stb,
	input  logic        we,
	input  logic [5:0]  adr,
	input  logic [31:0] dat_w,
	output logic        ack,
	output logic [31:0] dat_r,
	output logic        int_i2c,
	output logic [6:0]  slave_addr,
	output logic        soft_rst,
	output logic        rx_full,
	output logic        tx_empty,
	output logic [31:0] tx_word,
	input  logic        rx_push,
	input  logic [31:0] rx_word,
	input  logic        tx_pop,
	input  logic        wr_done,
	input  logic        rd_done,
	input  logic        rd_err,
	input  logic        brg_en,
	input  logic        download_done,
	output logic        dl_clr
);

	i2c_bridge_pkg::ctrl_word_u cmd;
	i2c_bridge_pkg::ctrl_word_u status;
	logic        access;
	logic        wr_ctrl;
	logic        wr_addr;
	logic        wr_tx;
	logic        rd_rx;
	logic        tx_flush;
	logic        rx_flush;
	logic        wr_done_flag;
	logic        rd_done_flag;
	logic        rd_err_flag;
	logic        irq_mask;
	logic [31:0] tx_din;
	logic        tx_wr;
	logic        rx_wr;
	logic        rx_rd;
	logic [31:0] rx_dout;
	logic [8:0]  tx_count;
	logic [8:0]  rx_count;
	logic [31:0] rd_val;

	assign access  = stb & ~ack;  // first cycle of a bus cycle
	assign cmd     = dat_w;
	assign wr_ctrl = access & we & (adr == i2c_bridge_pkg::REG_CTRL);
	assign wr_addr = access & we & (adr == i2c_bridge_pkg::REG_ADDR);
	assign wr_tx   = access & we & (adr == i2c_bridge_pkg::REG_TX);
	assign rd_rx   = access & ~we & (adr == i2c_bridge_pkg::REG_RX);
	assign dl_clr  = access & we & (adr == i2c_bridge_pkg::REG_RBT) & dat_w[0];

	assign rx_rd    = rd_rx & (rx_count != '0);  // empty read returns stale head
	assign rx_wr    = rx_push & ~brg_en;         // bridge mode drops host data
	assign rx_full  = rx_count >= (i2c_bridge_pkg::FIFO_DEPTH - i2c_bridge_pkg::PKG_LEN);
	assign tx_empty = tx_count < i2c_bridge_pkg::PKG_LEN;
	assign int_i2c  = (rx_count != '0) & ~irq_mask;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			ack        <= 1'b0;
			slave_addr <= 7'd0;
			soft_rst   <= 1'b0;
			tx_flush   <= 1'b0;
			rx_flush   <= 1'b0;
			tx_wr      <= 1'b0;
		end else begin
			ack      <= access;
			soft_rst <= wr_ctrl & cmd.wr.soft_rst;
			tx_flush <= wr_ctrl & cmd.wr.tx_flush;
			rx_flush <= wr_ctrl & cmd.wr.rx_flush;
			tx_wr    <= wr_tx;
			if (wr_addr) begin
				slave_addr <= dat_w[6:0];
			end
		end
	end

	// sticky status and interrupt mask
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wr_done_flag <= 1'b0;
			rd_done_flag <= 1'b0;
			rd_err_flag  <= 1'b0;
			irq_mask     <= 1'b1;
		end else if (soft_rst) begin
			wr_done_flag <= 1'b0;
			rd_done_flag <= 1'b0;
			rd_err_flag  <= 1'b0;
			irq_mask     <= 1'b1;
		end else begin
			if (wr_ctrl && cmd.wr.clr_wr_done)
				wr_done_flag <= 1'b0;
			else if (wr_done)
				wr_done_flag <= 1'b1;
			if (wr_ctrl && cmd.wr.clr_rd_done)
				rd_done_flag <= 1'b0;
			else if (rd_done)
				rd_done_flag <= 1'b1;
			if (wr_ctrl && cmd.wr.clr_rd_err)
				rd_err_flag <= 1'b0;
			else if (rd_err)
				rd_err_flag <= 1'b1;
			if (wr_ctrl && cmd.wr.mask)
				irq_mask <= 1'b1;
			else if (wr_ctrl && cmd.wr.unmask)
				irq_mask <= 1'b0;
		end
	end

	always_comb begin
		status             = '0;
		status.rd.mask     = irq_mask;
		status.rd.rd_err   = rd_err_flag;
		status.rd.rd_done  = rd_done_flag;
		status.rd.wr_done  = wr_done_flag;
		status.rd.tx_count = tx_count;
		status.rd.rx_count = rx_count;
		case (adr)
			i2c_bridge_pkg::REG_CTRL: rd_val = status;
			i2c_bridge_pkg::REG_ADDR: rd_val = {25'd0, slave_addr};
			i2c_bridge_pkg::REG_RX:   rd_val = rx_dout;
			i2c_bridge_pkg::REG_RBT:  rd_val = {31'd0, download_done};
			default:                  rd_val = i2c_bridge_pkg::UNMAPPED_DATA;  // also REG_TX
		endcase
	end

	always_ff @(posedge CLK_I) begin
		if (access && !we)
			dat_r <= rd_val;  // valid with ack
		if (wr_tx)
			tx_din <= dat_w;
	end

	word_fifo tx_fifo (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.flush (tx_flush),
		.wr_en (tx_wr),
		.din   (tx_din),
		.rd_en (tx_pop),
		.dout  (tx_word),
		.count (tx_count)
	);

	word_fifo rx_fifo (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.flush (rx_flush),
		.wr_en (rx_wr),
		.din   (rx_word),
		.rd_en (rx_rd),
		.dout  (rx_dout),
		.count (rx_count)
	);

	a_ack_one_cycle: assert property (@(posedge CLK_I) disable iff (RST_I)
		ack |=> !ack);

	// packet flow control must keep both queues from overrunning
	a_no_push_full: assert property (@(posedge CLK_I) disable iff (RST_I)
		(tx_wr |-> tx_count != i2c_bridge_pkg::FIFO_DEPTH) and
		(rx_wr |-> rx_count != i2c_bridge_pkg::FIFO_DEPTH));

endmodule

/* source/i2c_slave_phy.sv */
module i2c_slave_phy (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        soft_rst,
	input  logic        scl_pin,
	input  logic        sda_in,
	input  logic [6:0]  slave_addr,
	input  logic        rx_full,
	input  logic        tx_empty,
	input  logic [31:0] tx_word,
	output logic        sda_oe,
	output logic        rx_push,
	output logic [31:0] rx_word,
	output logic        tx_pop,
	output logic        wr_done,
	output logic        rd_done,
	output logic        rd_err,
	output logic [6:0]  cur_addr,
	output logic [7:0]  byte_data,
	output logic        byte_done,
	output logic        led_wr,
	output logic        led_rd
);

	logic [1:0] scl_sync;
	logic [1:0] sda_sync;
	logic       scl_d;
	logic       sda_d;
	logic       scl;
	logic       sda;
	logic       scl_rise;
	logic       scl_fall;
	logic       start_det;
	logic       stop_det;
	logic       in_addr;
	logic       in_wr;
	logic       in_rd;
	logic       busy;
	logic       ack_ph;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic [1:0] byte_idx;
	logic       own;
	logic       got_byte;
	logic       nack;
	logic       rd_end;
	logic       byte_end;
	logic       addr_hit;
	logic       brg_hit;
	logic [7:0] tx_byte;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			scl_sync <= 2'b11;  // idle bus is high
			sda_sync <= 2'b11;
			scl_d    <= 1'b1;
			sda_d    <= 1'b1;
		end else begin
			scl_sync <= {scl_sync[0], scl_pin};
			sda_sync <= {sda_sync[0], sda_in};
			scl_d    <= scl_sync[1];
			sda_d    <= sda_sync[1];
		end
	end

	assign scl       = scl_sync[1];
	assign sda       = sda_sync[1];
	assign scl_rise  = scl & ~scl_d;
	assign scl_fall  = ~scl & scl_d;
	assign start_det = scl & scl_d & sda_d & ~sda;  // sda falls, scl high
	assign stop_det  = scl & scl_d & ~sda_d & sda;
	assign busy      = in_addr | in_wr | in_rd;
	assign byte_end  = busy & scl_fall & ~ack_ph & (bit_cnt == 4'd8);
	assign addr_hit  = shreg[7:1] == slave_addr;
	assign brg_hit   = (shreg[7:1] == i2c_bridge_pkg::BRG_CMD_ADDR) ||
	                   (shreg[7:1] == i2c_bridge_pkg::BRG_DATA_ADDR);
	assign tx_byte   = tx_word[{~byte_idx, 3'b000} +: 8];  // msb byte first
	assign byte_data = shreg;
	assign led_wr    = in_wr;
	assign led_rd    = in_rd;

	always_ff @(posedge CLK_I) begin
		if (busy && scl_rise && !ack_ph && bit_cnt != 4'd8)
			shreg <= {shreg[6:0], sda};
		if (byte_end && in_wr && own)
			rx_word <= {rx_word[23:0], shreg};  // pack four bytes
	end

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			in_addr   <= 1'b0;
			in_wr     <= 1'b0;
			in_rd     <= 1'b0;
			ack_ph    <= 1'b0;
			bit_cnt   <= 4'd0;
			byte_idx  <= 2'd0;
			own       <= 1'b0;
			got_byte  <= 1'b0;
			nack      <= 1'b0;
			rd_end    <= 1'b0;
			sda_oe    <= 1'b0;
			cur_addr  <= 7'd0;
			rx_push   <= 1'b0;
			tx_pop    <= 1'b0;
			wr_done   <= 1'b0;
			rd_done   <= 1'b0;
			rd_err    <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			rx_push   <= 1'b0;
			tx_pop    <= 1'b0;
			wr_done   <= 1'b0;
			rd_done   <= 1'b0;
			rd_err    <= 1'b0;
			byte_done <= 1'b0;
			if (soft_rst) begin
				in_addr <= 1'b0;
				in_wr   <= 1'b0;
				in_rd   <= 1'b0;
				sda_oe  <= 1'b0;
			end else if (start_det) begin
				in_addr  <= 1'b1;
				in_wr    <= 1'b0;
				in_rd    <= 1'b0;
				ack_ph   <= 1'b0;
				bit_cnt  <= 4'd0;
				byte_idx <= 2'd0;
				own      <= 1'b0;
				sda_oe   <= 1'b0;
			end else if (stop_det) begin
				in_addr  <= 1'b0;
				in_wr    <= 1'b0;
				in_rd    <= 1'b0;
				sda_oe   <= 1'b0;
				wr_done  <= got_byte;
				rd_done  <= rd_end;
				got_byte <= 1'b0;
				rd_end   <= 1'b0;
			end else if (busy && scl_rise) begin
				if (ack_ph)
					nack <= sda;  // master answer on reads
				else if (bit_cnt != 4'd8)
					bit_cnt <= bit_cnt + 1'b1;
			end else if (busy && scl_fall) begin
				if (ack_ph) begin
					ack_ph  <= 1'b0;
					bit_cnt <= 4'd0;
					if (in_rd && !nack) begin
						sda_oe <= ~tx_byte[7];
					end else begin
						sda_oe <= 1'b0;
						rd_end <= in_rd;  // master ended the read
						in_rd  <= 1'b0;
					end
				end else if (bit_cnt == 4'd8) begin
					ack_ph <= 1'b1;
					if (in_addr) begin
						in_addr  <= 1'b0;
						cur_addr <= shreg[7:1];
						if (!shreg[0]) begin
							if ((addr_hit && !rx_full) || brg_hit) begin
								in_wr  <= 1'b1;
								own    <= addr_hit;
								sda_oe <= 1'b1;
							end
						end else if (addr_hit) begin
							if (tx_empty) begin
								rd_err <= 1'b1;  // less than a packet queued
							end else begin
								in_rd  <= 1'b1;
								sda_oe <= 1'b1;
							end
						end
					end else if (in_wr) begin
						sda_oe    <= 1'b1;
						byte_done <= 1'b1;
						if (own) begin
							byte_idx <= byte_idx + 1'b1;
							rx_push  <= byte_idx == 2'd3;
							got_byte <= 1'b1;
						end
					end else begin
						sda_oe   <= 1'b0;  // let the master answer
						byte_idx <= byte_idx + 1'b1;
						tx_pop   <= byte_idx == 2'd3;
					end
				end else if (in_rd) begin
					sda_oe <= ~tx_byte[3'd7 - bit_cnt[2:0]];
				end
			end
		end
	end

	// sda only changes while scl is low
	a_sda_setup: assert property (@(posedge CLK_I) disable iff (RST_I)
		$rose(sda_oe) |-> !scl);

endmodule

/* source/brg_ctrl.sv */
module brg_ctrl (
	input  logic       CLK_I,
	input  logic       RST_I,
	input  logic       soft_rst,
	input  logic [6:0] cur_addr,
	input  logic [7:0] byte_data,
	input  logic       byte_done,
	input  logic       dl_clr,
	output logic       brg_en,
	output logic       brg_cs,
	output logic       download_done,
	output logic       brg_sck,
	output logic       brg_mosi
);

	logic       cmd_vld;
	logic       dat_vld;
	logic       busy;
	logic [2:0] bit_cnt;
	logic [7:0] shift;

	assign cmd_vld = byte_done & (cur_addr == i2c_bridge_pkg::BRG_CMD_ADDR);
	assign dat_vld = byte_done & (cur_addr == i2c_bridge_pkg::BRG_DATA_ADDR);

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			brg_en        <= 1'b0;
			brg_cs        <= 1'b1;  // deselected
			download_done <= 1'b0;
		end else if (soft_rst) begin
			brg_en        <= 1'b0;
			brg_cs        <= 1'b1;
			download_done <= 1'b0;
		end else begin
			if (cmd_vld) begin
				case (byte_data)
					i2c_bridge_pkg::BRG_CS_ON:   brg_cs <= 1'b0;
					i2c_bridge_pkg::BRG_CS_OFF:  brg_cs <= 1'b1;
					i2c_bridge_pkg::BRG_EN_ON:   brg_en <= 1'b1;
					i2c_bridge_pkg::BRG_EN_OFF:  brg_en <= 1'b0;
					i2c_bridge_pkg::BRG_DL_DONE: download_done <= 1'b1;
					default: ;  // unknown command ignored
				endcase
			end
			if (dl_clr)
				download_done <= 1'b0;
		end
	end

	always_ff @(posedge CLK_I) begin
		if (dat_vld)
			shift <= byte_data;
		else if (busy && brg_sck)
			shift <= {1'b0, shift[7:1]};  // lsb goes out first
	end

	// one low and one high sck cycle per bit
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			busy     <= 1'b0;
			bit_cnt  <= 3'd0;
			brg_sck  <= 1'b0;
			brg_mosi <= 1'b0;
		end else if (soft_rst) begin
			busy     <= 1'b0;
			bit_cnt  <= 3'd0;
			brg_sck  <= 1'b0;
			brg_mosi <= 1'b0;
		end else if (dat_vld) begin
			busy     <= 1'b1;
			bit_cnt  <= 3'd0;
			brg_sck  <= 1'b0;
			brg_mosi <= byte_data[0];
		end else if (busy) begin
			if (!brg_sck) begin
				brg_sck <= 1'b1;
			end else begin
				brg_sck <= 1'b0;
				if (bit_cnt == 3'd7) begin
					busy     <= 1'b0;
					brg_mosi <= 1'b0;
				end else begin
					bit_cnt  <= bit_cnt + 1'b1;
					brg_mosi <= shift[1];
				end
			end
		end
	end

	// the byte period on i2c must cover a full shift
	a_no_overlap: assert property (@(posedge CLK_I) disable iff (RST_I)
		byte_done |-> !busy);

endmodule

/* source/i2c_bridge_top.sv */
module i2c_bridge_top (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        stb,
	input  logic        we,
	input  logic [5:0]  adr,
	input  logic [31:0] dat_w,
	output logic        ack,
	output logic [31:0] dat_r,
	input  logic        scl_pin,
	input  logic        sda_in,    // sampled pad level
	output logic        sda_oe,    // pull sda low
	output logic        int_i2c,
	output logic        brg_en,
	output logic        brg_cs,
	output logic        brg_sck,
	output logic        brg_mosi,
	output logic        led_wr,
	output logic        led_rd
);

	logic [6:0]  slave_addr;
	logic        soft_rst;
	logic        rx_full;
	logic        tx_empty;
	logic [31:0] tx_word;
	logic        rx_push;
	logic [31:0] rx_word;
	logic        tx_pop;
	logic        wr_done;
	logic        rd_done;
	logic        rd_err;
	logic [6:0]  cur_addr;
	logic [7:0]  byte_data;
	logic        byte_done;
	logic        dl_clr;
	logic        download_done;

	wb_reg_bank wb_reg_bank_inst (
		.CLK_I         (CLK_I),
		.RST_I         (RST_I),
		.stb           (stb),
		.we            (we),
		.adr           (adr),
		.dat_w         (dat_w),
		.ack           (ack),
		.dat_r         (dat_r),
		.int_i2c       (int_i2c),
		.slave_addr    (slave_addr),
		.soft_rst      (soft_rst),
		.rx_full       (rx_full),
		.tx_empty      (tx_empty),
		.tx_word       (tx_word),
		.rx_push       (rx_push),
		.rx_word       (rx_word),
		.tx_pop        (tx_pop),
		.wr_done       (wr_done),
		.rd_done       (rd_done),
		.rd_err        (rd_err),
		.brg_en        (brg_en),
		.download_done (download_done),
		.dl_clr        (dl_clr)
	);

	i2c_slave_phy i2c_slave_phy_inst (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.soft_rst   (soft_rst),
		.scl_pin    (scl_pin),
		.sda_in     (sda_in),
		.slave_addr (slave_addr),
		.rx_full    (rx_full),
		.tx_empty   (tx_empty),
		.tx_word    (tx_word),
		.sda_oe     (sda_oe),
		.rx_push    (rx_push),
		.rx_word    (rx_word),
		.tx_pop     (tx_pop),
		.wr_done    (wr_done),
		.rd_done    (rd_done),
		.rd_err     (rd_err),
		.cur_addr   (cur_addr),
		.byte_data  (byte_data),
		.byte_done  (byte_done),
		.led_wr     (led_wr),
		.led_rd     (led_rd)
	);

	brg_ctrl brg_ctrl_inst (
		.CLK_I         (CLK_I),
		.RST_I         (RST_I),
		.soft_rst      (soft_rst),
		.cur_addr      (cur_addr),
		.byte_data     (byte_data),
		.byte_done     (byte_done),
		.dl_clr        (dl_clr),
		.brg_en        (brg_en),
		.brg_cs        (brg_cs),
		.download_done (download_done),
		.brg_sck       (brg_sck),
		.brg_mosi      (brg_mosi)
	);

endmodule

/* dv/i2c_master_tasks.svh */
// I2C master model, one half-bit is 8 clocks

logic [31:0] lcg_state;

function automatic logic [7:0] lcg_byte();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state[31:24];  // upper bits are the most random
endfunction

function automatic logic [31:0] lcg_word();
	logic [31:0] w;
	w = {lcg_byte(), lcg_byte(), lcg_byte(), lcg_byte()};
	return w;
endfunction

// sda falls while scl is high
task automatic i2c_start();
	@(posedge CLK_I);
	sda_m <= 1'b0;
	repeat (8) @(posedge CLK_I);
	scl_pin <= 1'b0;
	repeat (4) @(posedge CLK_I);
endtask

// sda rises while scl is high
task automatic i2c_stop();
	sda_m <= 1'b0;
	repeat (4) @(posedge CLK_I);
	scl_pin <= 1'b1;
	repeat (8) @(posedge CLK_I);
	sda_m <= 1'b1;
	repeat (8) @(posedge CLK_I);
endtask

// one scl period, drives b and samples the line mid high
task automatic i2c_bit(input logic b, output logic s);
	sda_m <= b;
	repeat (4) @(posedge CLK_I);
	scl_pin <= 1'b1;
	repeat (4) @(posedge CLK_I);
	s = sda_line;
	repeat (4) @(posedge CLK_I);
	scl_pin <= 1'b0;
	repeat (4) @(posedge CLK_I);
endtask

task automatic i2c_write_byte(input logic [7:0] b, output logic acked);
	logic s;
	for (int i = 7; i >= 0; i--)
		i2c_bit(b[i], s);
	i2c_bit(1'b1, s);  // release for slave ack
	acked = !s;
endtask

task automatic i2c_read_byte(output logic [7:0] b, input logic last);
	logic s;
	b = '0;
	for (int i = 0; i < 8; i++) begin
		i2c_bit(1'b1, s);
		b = {b[6:0], s};
	end
	i2c_bit(last, s);  // nack on the last byte
endtask

/* dv/tb_top.sv */
module tb_top;

	localparam int         MAX_CYCLES = 400000;
	localparam logic [6:0] SADDR      = 7'h2a;

	logic        CLK_I;
	logic        RST_I;
	logic        stb;
	logic        we;
	logic [5:0]  adr;
	logic [31:0] dat_w;
	logic        ack;
	logic [31:0] dat_r;
	logic        scl_pin;
	logic        sda_m;
	logic        sda_line;
	logic        sda_oe;
	logic        int_i2c;
	logic        brg_en;
	logic        brg_cs;
	logic        brg_sck;
	logic        brg_mosi;
	logic        led_wr;
	logic        led_rd;
	int          cycle_cnt = 0;
	logic [31:0] exp_q[$];
	logic        sck_d;
	logic [7:0]  mosi_bits;
	int          mosi_cnt;

	assign sda_line = sda_m & ~sda_oe;  // open drain bus

	i2c_bridge_top i2c_bridge_top_inst (
		.CLK_I    (CLK_I),
		.RST_I    (RST_I),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.dat_w    (dat_w),
		.ack      (ack),
		.dat_r    (dat_r),
		.scl_pin  (scl_pin),
		.sda_in   (sda_line),
		.sda_oe   (sda_oe),
		.int_i2c  (int_i2c),
		.brg_en   (brg_en),
		.brg_cs   (brg_cs),
		.brg_sck  (brg_sck),
		.brg_mosi (brg_mosi),
		.led_wr   (led_wr),
		.led_rd   (led_rd)
	);

	initial begin
		CLK_I = 1'b0;
		forever #10 CLK_I = ~CLK_I;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else
			stop_run($sformatf("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	// control word as seen on read
	function automatic logic [31:0] ctrl_val(input logic mask, input logic rd_err,
		input logic rd_done, input logic wr_done, input int tx, input int rx);
		logic [31:0] v;
		v       = '0;
		v[24]   = mask;
		v[20]   = rd_err;
		v[19]   = rd_done;
		v[18]   = wr_done;
		v[17:9] = tx[8:0];
		v[8:0]  = rx[8:0];
		return v;
	endfunction

	`include "i2c_master_tasks.svh"

	task automatic wb_write(input logic [5:0] a, input logic [31:0] d);
		@(posedge CLK_I);
		stb   <= 1'b1;
		we    <= 1'b1;
		adr   <= a;
		dat_w <= d;
		@(posedge CLK_I);
		check_val("ack", 1'b0, ack);
		@(posedge CLK_I);
		check_val("ack", 1'b1, ack);
		stb <= 1'b0;
		we  <= 1'b0;
		repeat (2) @(posedge CLK_I);  // let pulses settle
	endtask

	task automatic read_check(input string name, input logic [5:0] a, input logic [31:0] exp);
		@(posedge CLK_I);
		stb <= 1'b1;
		we  <= 1'b0;
		adr <= a;
		@(posedge CLK_I);
		check_val("ack", 1'b0, ack);
		@(posedge CLK_I);
		check_val("ack", 1'b1, ack);
		check_val(name, exp, dat_r);
		stb <= 1'b0;
		repeat (2) @(posedge CLK_I);
	endtask

	task automatic i2c_write_xfer(input logic [6:0] a, input int n, input logic exp_ack,
		input logic keep);
		logic        acked;
		logic [7:0]  b;
		logic [31:0] w;
		w = '0;
		i2c_start();
		i2c_write_byte({a, 1'b0}, acked);
		check_val("address ack", exp_ack, acked);
		check_val("led_wr", exp_ack, led_wr);
		check_val("led_rd", 1'b0, led_rd);
		for (int i = 0; i < n && acked; i++) begin
			b = lcg_byte();
			w = {w[23:0], b};
			i2c_write_byte(b, acked);
			check_val("data ack", 1'b1, acked);
			if (keep && i % 4 == 3)
				exp_q.push_back(w);
		end
		i2c_stop();
		check_val("led_wr", 1'b0, led_wr);
	endtask

	task automatic i2c_write_one(input logic [6:0] a, input logic [7:0] b);
		logic acked;
		i2c_start();
		i2c_write_byte({a, 1'b0}, acked);
		check_val("bridge address ack", 1'b1, acked);
		i2c_write_byte(b, acked);
		check_val("bridge data ack", 1'b1, acked);
		i2c_stop();
	endtask

	assert property (@(posedge CLK_I) disable iff (RST_I) (stb && !ack) |=> ack)
		else stop_run("host bus ack did not follow stb after one cycle");
	assert property (@(posedge CLK_I) disable iff (RST_I) ack |=> !ack)
		else stop_run("host bus ack stayed high for two cycles");
	assert property (@(posedge CLK_I) disable iff (RST_I) $rose(brg_sck) |-> $stable(brg_mosi))
		else stop_run("brg_mosi changed at a brg_sck rise");

	// collect bridge bits at each sck rise
	always @(posedge CLK_I) begin
		if (RST_I) begin
			sck_d    <= 1'b0;
			mosi_cnt <= 0;
		end else begin
			sck_d <= brg_sck;
			if (brg_sck && !sck_d) begin
				mosi_bits <= {brg_mosi, mosi_bits[7:1]};  // lsb arrives first
				mosi_cnt  <= mosi_cnt + 1;
			end
		end
	end

	always @(posedge CLK_I) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES)
			stop_run("timeout, the test sequence did not finish within the cycle limit");
	end

	initial begin
		logic        acked;
		logic [7:0]  b;
		logic [31:0] w;
		int          start_m;
		RST_I     = 1'b1;
		stb       = 1'b0;
		we        = 1'b0;
		adr       = '0;
		dat_w     = '0;
		scl_pin   = 1'b1;
		sda_m     = 1'b1;
		lcg_state = 32'd49921;
		repeat (8) @(posedge CLK_I);
		RST_I <= 1'b0;
		repeat (4) @(posedge CLK_I);

		// register access
		read_check("ctrl after reset", i2c_bridge_pkg::REG_CTRL, ctrl_val(1, 0, 0, 0, 0, 0));
		check_val("brg_cs", 1'b1, brg_cs);
		check_val("brg_en", 1'b0, brg_en);
		check_val("int_i2c", 1'b0, int_i2c);
		wb_write(i2c_bridge_pkg::REG_ADDR, {25'd0, SADDR});
		read_check("slave address", i2c_bridge_pkg::REG_ADDR, {25'd0, SADDR});
		read_check("unmapped", 6'h10, i2c_bridge_pkg::UNMAPPED_DATA);
		read_check("tx readback", i2c_bridge_pkg::REG_TX, i2c_bridge_pkg::UNMAPPED_DATA);

		// I2C write of two words
		i2c_write_xfer(SADDR, 8, 1'b1, 1'b1);
		read_check("ctrl after write", i2c_bridge_pkg::REG_CTRL, ctrl_val(1, 0, 0, 1, 0, 2));
		check_val("int_i2c", 1'b0, int_i2c);
		wb_write(i2c_bridge_pkg::REG_CTRL, 32'h0200_0000);
		check_val("int_i2c", 1'b1, int_i2c);
		read_check("rx word", i2c_bridge_pkg::REG_RX, exp_q.pop_front());
		read_check("rx word", i2c_bridge_pkg::REG_RX, exp_q.pop_front());
		check_val("int_i2c", 1'b0, int_i2c);
		wb_write(i2c_bridge_pkg::REG_CTRL, 32'h0004_0000);
		read_check("ctrl after clear", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 0, 0, 0, 0, 0));

		// I2C read first refused then a full packet
		i2c_start();
		i2c_write_byte({SADDR, 1'b1}, acked);
		check_val("read address ack", 1'b0, acked);
		check_val("led_rd", 1'b0, led_rd);
		i2c_stop();
		read_check("ctrl read error", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 1, 0, 0, 0, 0));
		for (int i = 0; i < 10; i++) begin
			w = lcg_word();
			exp_q.push_back(w);
			wb_write(i2c_bridge_pkg::REG_TX, w);
		end
		read_check("ctrl tx loaded", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 1, 0, 0, 10, 0));
		i2c_start();
		i2c_write_byte({SADDR, 1'b1}, acked);
		check_val("read address ack", 1'b1, acked);
		check_val("led_rd", 1'b1, led_rd);
		check_val("led_wr", 1'b0, led_wr);
		w = '0;
		for (int i = 0; i < 40; i++) begin
			i2c_read_byte(b, i == 39);
			w = {w[23:0], b};
			if (i % 4 == 3)
				check_val("i2c read word", exp_q.pop_front(), w);
		end
		i2c_stop();
		check_val("led_rd", 1'b0, led_rd);
		read_check("ctrl after read", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 1, 1, 0, 0, 0));
		wb_write(i2c_bridge_pkg::REG_CTRL, 32'h0018_0000);

		// fill the receive queue to the packet limit
		i2c_write_xfer(SADDR, 984, 1'b1, 1'b0);
		read_check("ctrl filled", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 0, 0, 1, 0, 246));
		check_val("int_i2c", 1'b1, int_i2c);
		i2c_write_xfer(SADDR, 4, 1'b0, 1'b0);
		read_check("ctrl refused", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 0, 0, 1, 0, 246));
		wb_write(i2c_bridge_pkg::REG_CTRL, 32'h0024_0000);
		read_check("ctrl flushed", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 0, 0, 0, 0, 0));
		i2c_write_xfer(SADDR, 4, 1'b1, 1'b1);
		read_check("ctrl accepted", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 0, 0, 1, 0, 1));

		// bridge commands and serial data
		i2c_write_one(i2c_bridge_pkg::BRG_CMD_ADDR, i2c_bridge_pkg::BRG_CS_ON);
		i2c_write_one(i2c_bridge_pkg::BRG_CMD_ADDR, i2c_bridge_pkg::BRG_EN_ON);
		check_val("brg_cs", 1'b0, brg_cs);
		check_val("brg_en", 1'b1, brg_en);
		start_m = mosi_cnt;
		b = lcg_byte();
		i2c_write_one(i2c_bridge_pkg::BRG_DATA_ADDR, b);
		for (int k = 0; k < 200 && mosi_cnt != start_m + 8; k++)
			@(posedge CLK_I);
		check_val("brg_sck rises", start_m + 8, mosi_cnt);
		check_val("brg_mosi", b, mosi_bits);
		i2c_write_xfer(SADDR, 4, 1'b1, 1'b0);  // dropped in bridge mode
		read_check("ctrl bridge mode", i2c_bridge_pkg::REG_CTRL, ctrl_val(0, 0, 0, 1, 0, 1));
		i2c_write_one(i2c_bridge_pkg::BRG_CMD_ADDR, i2c_bridge_pkg::BRG_DL_DONE);
		read_check("download done", i2c_bridge_pkg::REG_RBT, 32'd1);
		wb_write(i2c_bridge_pkg::REG_RBT, 32'd1);
		read_check("download cleared", i2c_bridge_pkg::REG_RBT, 32'd0);
		i2c_write_one(i2c_bridge_pkg::BRG_CMD_ADDR, i2c_bridge_pkg::BRG_DL_DONE);

		// soft reset then a transmit flush
		wb_write(i2c_bridge_pkg::REG_CTRL, 32'h0080_0000);
		check_val("brg_en", 1'b0, brg_en);
		check_val("brg_cs", 1'b1, brg_cs);
		read_check("download after reset", i2c_bridge_pkg::REG_RBT, 32'd0);
		read_check("ctrl soft reset", i2c_bridge_pkg::REG_CTRL, ctrl_val(1, 0, 0, 0, 0, 1));
		for (int i = 0; i < 3; i++)
			wb_write(i2c_bridge_pkg::REG_TX, lcg_word());
		read_check("ctrl tx three", i2c_bridge_pkg::REG_CTRL, ctrl_val(1, 0, 0, 0, 3, 1));
		wb_write(i2c_bridge_pkg::REG_CTRL, 32'h0040_0000);
		read_check("ctrl tx flush", i2c_bridge_pkg::REG_CTRL, ctrl_val(1, 0, 0, 0, 0, 1));
		read_check("rx word", i2c_bridge_pkg::REG_RX, exp_q.pop_front());
		read_check("ctrl final", i2c_bridge_pkg::REG_CTRL, ctrl_val(1, 0, 0, 0, 0, 0));

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* files.f */
source/i2c_bridge_pkg.sv
source/word_fifo.sv
source/wb_reg_bank.sv
source/i2c_slave_phy.sv
source/brg_ctrl.sv
source/i2c_bridge_top.sv
+incdir+dv
dv/tb_top.sv

/* Makefile */
# Verilator build and run of the I2C bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
